// File: list.f
+incdir+rtl
rtl/tmr_pkg.sv
rtl/tmr_channel.sv
rtl/tmr_irq_combine.sv
rtl/tmr_apb_regs.sv
rtl/tmr_top.sv
verif/tmr_assert.sv
verif/tmr_tb.sv

// File: rtl/tmr_apb_regs.sv
`timescale 1ns/1ps
`include "tmr_macros.svh"

module tmr_apb_regs (
	input  logic                     clk_i,
	input  logic                     rst_i,
	input  logic                     psel_i,
	input  logic                     penable_i,
	input  logic                     pwrite_i,
	input  tmr_pkg::tmr_addr_t       paddr_i,
	input  tmr_pkg::tmr_word_t       pwdata_i,
	input  tmr_pkg::tmr_strb_t       pstrb_i,
	output tmr_pkg::tmr_word_t       prdata_o,
	output logic                     pready_o,
	output logic                     pslverr_o,
	output logic [1:0]               enable_o,
	output logic [1:0]               count_up_o,
	output logic [1:0]               clr_count_o,
	output logic [1:0]               clr_events_o,
	output tmr_pkg::tmr_word_t [1:0] prescale_o,
	output tmr_pkg::tmr_word_t [1:0] reload_o,
	input  tmr_pkg::tmr_word_t [1:0] count_i,
	input  tmr_pkg::tmr_word_t [1:0] events_i,
	input  logic [1:0]               pending_i,
	output logic [1:0]               mask_o
);
	import tmr_pkg::*;

	localparam tmr_addr_t CH_END = 2 * `TMR_CH_STRIDE;

	tmr_word_t [1:0] prescale_q;
	tmr_word_t [1:0] reload_q;
	logic [1:0]      enable_q;
	logic [1:0]      count_up_q;
	logic [1:0]      clr_count_q;
	logic [1:0]      clr_events_q;
	logic [1:0]      mask_q;
	logic            wr_en;
	logic            in_ch;
	logic            ch_sel;
	tmr_reg_e        ch_off;

	function automatic tmr_word_t strb_merge(input tmr_word_t cur, input tmr_word_t wdata,
		input tmr_strb_t strb);
		tmr_word_t res;
		res = cur;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				res[8*b +: 8] = wdata[8*b +: 8];
			end
		end
		return res;
	endfunction

	assign wr_en = psel_i && penable_i && pwrite_i; // access cycle of a write.
	assign in_ch = (paddr_i < CH_END);
	assign ch_sel = (paddr_i >= `TMR_CH_STRIDE);
	assign ch_off = tmr_reg_e'(ch_sel ? paddr_i - `TMR_CH_STRIDE : paddr_i);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			prescale_q <= '1;
			reload_q <= '1;
			enable_q <= '0;
			count_up_q <= '0; // down.
			clr_count_q <= '0;
			clr_events_q <= '0;
			mask_q <= '0;
		end else begin
			clr_count_q <= '0;
			clr_events_q <= '0;
			if (wr_en && in_ch) begin
				case (ch_off)
					REG_PRESCALE: prescale_q[ch_sel] <= strb_merge(prescale_q[ch_sel], pwdata_i, pstrb_i);
					REG_RELOAD: reload_q[ch_sel] <= strb_merge(reload_q[ch_sel], pwdata_i, pstrb_i);
					REG_CTRL: begin
						if (pstrb_i[0]) begin
							enable_q[ch_sel] <= pwdata_i[CTRL_ENABLE];
							count_up_q[ch_sel] <= pwdata_i[CTRL_UP];
							clr_count_q[ch_sel] <= pwdata_i[CTRL_CLR_COUNT]; // one cycle pulse.
							clr_events_q[ch_sel] <= pwdata_i[CTRL_CLR_EVENTS];
						end
					end
					default: ;
				endcase
			end else if (wr_en && paddr_i == REG_IRQ_MASK && pstrb_i[0]) begin
				mask_q <= pwdata_i[1:0];
			end
		end
	end

	always_comb begin
		prdata_o = '0;
		if (in_ch) begin
			case (ch_off)
				REG_PRESCALE: prdata_o = prescale_q[ch_sel];
				REG_RELOAD: prdata_o = reload_q[ch_sel];
				REG_CTRL: begin
					prdata_o[CTRL_ENABLE] = enable_q[ch_sel];
					prdata_o[CTRL_UP] = count_up_q[ch_sel];
				end
				REG_COUNT: prdata_o = count_i[ch_sel];
				REG_EVENTS: prdata_o = events_i[ch_sel];
				default: prdata_o = '0;
			endcase
		end else if (paddr_i == REG_IRQ_STATUS) begin
			prdata_o[1:0] = pending_i;
		end else if (paddr_i == REG_IRQ_MASK) begin
			prdata_o[1:0] = mask_q;
		end
	end

	assign pready_o = 1'b1; // no wait states.
	assign pslverr_o = 1'b0;

	assign enable_o = enable_q;
	assign count_up_o = count_up_q;
	assign clr_count_o = clr_count_q;
	assign clr_events_o = clr_events_q;
	assign prescale_o = prescale_q;
	assign reload_o = reload_q;
	assign mask_o = mask_q;

endmodule

// File: rtl/tmr_channel.sv
`timescale 1ns/1ps
`include "tmr_macros.svh"

module tmr_channel (
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic               enable_i,
	input  logic               count_up_i,
	input  tmr_pkg::tmr_word_t prescale_i,
	input  tmr_pkg::tmr_word_t reload_i,
	input  logic               clr_count_i,
	input  logic               clr_events_i,
	output tmr_pkg::tmr_word_t count_o,
	output tmr_pkg::tmr_word_t events_o,
	output logic               event_o
);
	import tmr_pkg::*;

	tmr_word_t presc_cnt_q;
	tmr_word_t presc_cnt;
	tmr_word_t presc_limit;
	tmr_word_t prescale_q;
	tmr_word_t count_q;
	tmr_word_t events_q;
	logic      event_q;
	logic      tick;
	logic      wrap;

	// all ones selects the one second period.
	assign presc_limit = (&prescale_i) ? tmr_word_t'(`TMR_CLK_FREQ - 1) : prescale_i;

	assign presc_cnt = (prescale_i != prescale_q) ? '0 : presc_cnt_q; // new value restarts.
	assign tick = enable_i && (presc_cnt == presc_limit);
	assign wrap = tick && (count_q == reload_i);

	// held at zero while disabled, so counting starts fresh on enable.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			presc_cnt_q <= '0;
			prescale_q <= '1; // matches the register reset value.
		end else begin
			prescale_q <= prescale_i;
			if (!enable_i || tick) begin
				presc_cnt_q <= '0;
			end else begin
				presc_cnt_q <= presc_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			count_q <= '0;
			events_q <= '0;
			event_q <= 1'b0;
		end else begin
			event_q <= wrap;
			if (clr_count_i) begin
				count_q <= '0; // clear beats a tick.
			end else if (wrap) begin
				count_q <= '0;
			end else if (tick) begin
				if (count_up_i) begin
					count_q <= count_q + 1'b1;
				end else begin
					count_q <= count_q - 1'b1;
				end
			end

			if (clr_events_i) begin
				events_q <= '0;
			end else if (wrap) begin
				events_q <= events_q + 1'b1;
			end
		end
	end

	assign count_o = count_q;
	assign events_o = events_q;
	assign event_o = event_q;

endmodule

// File: rtl/tmr_irq_combine.sv
`timescale 1ns/1ps

module tmr_irq_combine (
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic [1:0] event_i,
	input  logic [1:0] mask_i,
	input  logic       irq_ack_i,
	output logic [1:0] pending_o,
	output logic       irq_o
);

	logic [1:0] pending_q;
	logic [1:0] active;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pending_q <= '0;
		end else begin
			for (int c = 0; c < 2; c++) begin
				if (event_i[c]) begin
					pending_q[c] <= 1'b1; // a new event wins over the ack.
				end else if (irq_ack_i) begin
					pending_q[c] <= 1'b0;
				end
			end
		end
	end

	// masked flags only.
	assign active = pending_q & mask_i;

	assign pending_o = pending_q;
	assign irq_o = |active;

endmodule

// File: rtl/tmr_macros.svh
`ifndef TMR_MACROS_SVH
`define TMR_MACROS_SVH

// core clock in hertz, one tick per second with an all-ones prescale.
`define TMR_CLK_FREQ 125000000

// APB byte address width.
`define TMR_ADDR_W 7

// distance between the two channel register groups.
`define TMR_CH_STRIDE 7'h20

`endif

// File: rtl/tmr_pkg.sv
`include "tmr_macros.svh"

package tmr_pkg;

	typedef logic [31:0] tmr_word_t;
	typedef logic [`TMR_ADDR_W-1:0] tmr_addr_t;
	typedef logic [3:0] tmr_strb_t;

	// channel offsets are relative to the group base.
	typedef enum logic [`TMR_ADDR_W-1:0] {
		REG_PRESCALE   = 7'h00,
		REG_RELOAD     = 7'h04,
		REG_CTRL       = 7'h08,
		REG_COUNT      = 7'h0C,
		REG_EVENTS     = 7'h10,
		REG_IRQ_STATUS = 7'h40,
		REG_IRQ_MASK   = 7'h44
	} tmr_reg_e;

	// CTRL bits; the two clear bits are write-one commands and read back as zero.
	localparam int CTRL_ENABLE     = 0;
	localparam int CTRL_UP         = 1; // 0 counts down.
	localparam int CTRL_CLR_COUNT  = 2;
	localparam int CTRL_CLR_EVENTS = 3;

endpackage

// File: rtl/tmr_top.sv
`timescale 1ns/1ps

module tmr_top (
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic               psel_i,
	input  logic               penable_i,
	input  logic               pwrite_i,
	input  tmr_pkg::tmr_addr_t paddr_i,
	input  tmr_pkg::tmr_word_t pwdata_i,
	input  tmr_pkg::tmr_strb_t pstrb_i,
	output tmr_pkg::tmr_word_t prdata_o,
	output logic               pready_o,
	output logic               pslverr_o,
	input  logic               irq_ack_i,
	output logic               irq_o
);
	import tmr_pkg::*;

	logic [1:0]      enable;
	logic [1:0]      count_up;
	logic [1:0]      clr_count;
	logic [1:0]      clr_events;
	logic [1:0]      ch_event;
	logic [1:0]      mask;
	logic [1:0]      pending;
	tmr_word_t [1:0] prescale;
	tmr_word_t [1:0] reload;
	tmr_word_t [1:0] count;
	tmr_word_t [1:0] events;

	tmr_apb_regs u_regs (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.psel_i       (psel_i),
		.penable_i    (penable_i),
		.pwrite_i     (pwrite_i),
		.paddr_i      (paddr_i),
		.pwdata_i     (pwdata_i),
		.pstrb_i      (pstrb_i),
		.prdata_o     (prdata_o),
		.pready_o     (pready_o),
		.pslverr_o    (pslverr_o),
		.enable_o     (enable),
		.count_up_o   (count_up),
		.clr_count_o  (clr_count),
		.clr_events_o (clr_events),
		.prescale_o   (prescale),
		.reload_o     (reload),
		.count_i      (count),
		.events_i     (events),
		.pending_i    (pending),
		.mask_o       (mask)
	);

	// both channels run side by side.
	for (genvar c = 0; c < 2; c++) begin : g_ch
		tmr_channel u_ch (
			.clk_i        (clk_i),
			.rst_i        (rst_i),
			.enable_i     (enable[c]),
			.count_up_i   (count_up[c]),
			.prescale_i   (prescale[c]),
			.reload_i     (reload[c]),
			.clr_count_i  (clr_count[c]),
			.clr_events_i (clr_events[c]),
			.count_o      (count[c]),
			.events_o     (events[c]),
			.event_o      (ch_event[c])
		);
	end

	tmr_irq_combine u_irq (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.event_i   (ch_event),
		.mask_i    (mask),
		.irq_ack_i (irq_ack_i),
		.pending_o (pending),
		.irq_o     (irq_o)
	);

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the timer testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	-f list.f --top-module tmr_tb -o tmr_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tmr_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi
echo "simulation passed"
exit 0

// File: verif/tmr_assert.sv
`timescale 1ns/1ps

module tmr_assert (
	input logic       clk_i,
	input logic       rst_i,
	input logic       psel_i,
	input logic       penable_i,
	input logic       pslverr_i,
	input logic       irq_ack_i,
	input logic [1:0] event_i,
	input logic       irq_i
);

	// access cycle only after a setup cycle.
	penable_after_psel: assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(penable_i) |-> $past(psel_i))
		else $error("penable_i rose without psel_i in the cycle before");

	no_slave_error: assert property (@(posedge clk_i) disable iff (rst_i) !pslverr_i)
		else $error("pslverr_o was driven high");

	irq_low_after_reset: assert property (@(posedge clk_i) rst_i |=> !irq_i)
		else $error("irq_o was high in the cycle after reset");

	// a same-cycle event keeps its flag.
	irq_falls_on_ack: assert property (@(posedge clk_i) disable iff (rst_i)
		irq_ack_i && !(|event_i) |=> !irq_i)
		else $error("irq_o stayed high after an acknowledge");

endmodule

bind tmr_top tmr_assert u_assert (
	.clk_i     (clk_i),
	.rst_i     (rst_i),
	.psel_i    (psel_i),
	.penable_i (penable_i),
	.pslverr_i (pslverr_o),
	.irq_ack_i (irq_ack_i),
	.event_i   (ch_event),
	.irq_i     (irq_o)
);

// File: verif/tmr_tb.sv
`timescale 1ns/1ps

module tmr_tb;
	import tmr_pkg::*;

	localparam int APB_WAIT_MAX = 16;
	localparam int IRQ_WAIT_MAX = 200;

	logic      clk;
	logic      rst;
	logic      psel;
	logic      penable;
	logic      pwrite;
	tmr_addr_t paddr;
	tmr_word_t pwdata;
	tmr_strb_t pstrb;
	tmr_word_t prdata;
	logic      pready;
	logic      pslverr;
	logic      irq_ack;
	logic      irq;

	tmr_top dut (
		.clk_i     (clk),
		.rst_i     (rst),
		.psel_i    (psel),
		.penable_i (penable),
		.pwrite_i  (pwrite),
		.paddr_i   (paddr),
		.pwdata_i  (pwdata),
		.pstrb_i   (pstrb),
		.prdata_o  (prdata),
		.pready_o  (pready),
		.pslverr_o (pslverr),
		.irq_ack_i (irq_ack),
		.irq_o     (irq)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run();
		$display("Test FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input tmr_word_t got, input tmr_word_t exp, input tmr_addr_t addr);
		if (got !== exp) begin
			$display("ERR %0t: read of 0x%02h gave 0x%08h, expected 0x%08h", $time, addr, got, exp);
			abort_run();
		end
	endtask

	task automatic check_irq(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t: irq_o is %b %s, expected %b", $time, got, what, exp);
			abort_run();
		end
	endtask

	task automatic bad_line(input int num);
		$display("trace line %0d is not a valid operation", num);
		abort_run();
	endtask

	// stretches the access phase until the slave is ready.
	task automatic wait_pready();
		int waited;
		waited = 0;
		while (pready !== 1'b1) begin
			if (waited == APB_WAIT_MAX) begin
				$display("APB transfer to 0x%02h saw no pready within %0d cycles", paddr, waited);
				abort_run();
			end else begin
				@(negedge clk);
				waited++;
			end
		end
	endtask

	task automatic apb_write(input tmr_addr_t addr, input tmr_word_t data, input tmr_strb_t strb);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		pstrb = strb;
		@(negedge clk);
		penable = 1'b1;
		wait_pready();
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input tmr_addr_t addr, input tmr_word_t exp);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		pstrb = '0;
		@(negedge clk);
		penable = 1'b1;
		wait_pready();
		check_word(prdata, exp, addr); // mid cycle, registers settled.
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic wait_irq(input logic level);
		int waited;
		waited = 0;
		while (irq !== level) begin
			if (waited == IRQ_WAIT_MAX) begin
				$display("irq_o did not reach %b within %0d cycles", level, waited);
				abort_run();
			end else begin
				@(negedge clk);
				waited++;
			end
		end
	endtask

	// flags clear on the edge inside the pulse.
	task automatic ack_pulse();
		irq_ack = 1'b1;
		@(negedge clk);
		irq_ack = 1'b0;
		check_irq(irq, 1'b0, "one cycle after the acknowledge");
	endtask

	initial begin
		int          fd;
		int          n;
		int          line_no;
		int          f_cnt;
		string       line;
		string       rest;
		logic [7:0]  op;
		tmr_addr_t   f_addr;
		tmr_word_t   f_data;
		tmr_strb_t   f_strb;

		$timeformat(-9, 0, " ns", 0);
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		pstrb = '0;
		irq_ack = 1'b0;
		line_no = 0;
		fd = $fopen("verif/tmr_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file verif/tmr_trace.txt");
			abort_run();
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		while ($fgets(line, fd) != 0) begin
			line_no++;
			op = line.getc(0);
			rest = line.substr(1, line.len() - 1);
			case (op)
				"W": begin
					n = $sscanf(rest, "%h %h %h", f_addr, f_data, f_strb);
					if (n != 3) begin
						bad_line(line_no);
					end else begin
						apb_write(f_addr, f_data, f_strb);
					end
				end
				"R": begin
					n = $sscanf(rest, "%h %h", f_addr, f_data);
					if (n != 2) begin
						bad_line(line_no);
					end else begin
						apb_read(f_addr, f_data);
					end
				end
				"I", "Q": begin
					n = $sscanf(rest, "%d", f_cnt);
					if (n != 1) begin
						bad_line(line_no);
					end else if (op == "I") begin
						repeat (f_cnt) @(negedge clk);
					end else begin
						wait_irq(f_cnt != 0);
					end
				end
				"A": ack_pulse();
				"#", 8'h0a, 8'h0d: ; // comment or blank line.
				default: bad_line(line_no);
			endcase
		end
		$fclose(fd);

		$display("Test OK");
		$finish;
	end

endmodule

// File: verif/tmr_trace.txt
# W addr data strobe: APB write; R addr expected: APB read and compare (all hex)
# I cycles: idle; Q level: wait for irq_o with timeout (decimal); A: acknowledge pulse
R 00 ffffffff
R 04 ffffffff
R 08 00000000
R 0c 00000000
R 10 00000000
R 24 ffffffff
R 40 00000000
R 44 00000000
W 00 12345678 5
R 00 ff34ff78
W 04 aabbccdd a
R 04 aaffccff
W 00 00000001 f
W 04 00000003 f
W 08 00000003 f
I 20
R 0c 00000002
R 10 00000002
W 08 00000002 f
W 20 00000000 f
W 24 fffffffd f
W 28 00000001 f
I 4
R 2c ffffffff
R 30 00000001
W 28 00000000 f
I 2
A
R 40 00000000
W 44 00000001 f
W 24 00000000 f
W 28 00000005 f
W 28 00000000 f
I 2
R 40 00000002
Q 0
W 08 00000003 f
Q 1
R 40 00000003
W 08 00000002 f
I 2
A
Q 0
R 40 00000000
W 08 00000006 f
W 08 00000003 f
I 2
R 0c 00000001
W 08 00000006 f
R 0c 00000000
W 28 00000008 f
W 28 00000001 f
R 30 00000001
W 28 00000008 f
R 30 00000000
